/* Bender.yml */
package:
  name: idex_unit

sources:
  - files:
      - rtl/rv_isa_pkg.sv
      - rtl/idex_ctrl_pkg.sv
      - rtl/decode_if.sv
      - rtl/idex_decoder.sv
      - rtl/int_alu.sv
      - rtl/branch_unit.sv
      - rtl/retire_ctrl.sv
      - rtl/idex_unit.sv
  - target: test
    files:
      - dv/idex_unit_sva.sv
      - dv/idex_unit_tb.sv

/* dv/idex_unit_sva.sv */
module idex_unit_sva import idex_ctrl_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      req_i,
    input logic      ack_i,
    input logic      rd_we_i,
    input reg_addr_t rd_addr_i,
    input word_t     rd_data_i,
    input word_t     pc_next_i,
    input logic      inst_err_i
);

    ack_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !ack_i)
        else $error("ack_o high during reset");

    ack_low_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !ack_i)
        else $error("ack_o high right after reset");

    ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i && !ack_i) |=> ack_i)
        else $error("ack_o did not rise one cycle after req_i");

    ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!req_i && ack_i) |=> !ack_i)
        else $error("ack_o did not fall one cycle after req_i dropped");

    results_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> ($stable(rd_we_i) && $stable(rd_addr_i) && $stable(rd_data_i)
                   && $stable(pc_next_i) && $stable(inst_err_i)))
        else $error("results changed while ack_o was high");

endmodule

bind idex_unit idex_unit_sva u_sva (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .ack_i      (ack_o),
    .rd_we_i    (rd_we_o),
    .rd_addr_i  (rd_addr_o),
    .rd_data_i  (rd_data_o),
    .pc_next_i  (pc_next_o),
    .inst_err_i (inst_err_o)
);

/* dv/idex_unit_tb.sv */
module idex_unit_tb import idex_ctrl_pkg::*; import rv_isa_pkg::*; ();

    localparam int N_TXN   = 2000;
    localparam int TIMEOUT = 50; // cycles per handshake phase

    logic      clk_i;
    logic      rst_n_i;
    logic      req_i;
    word_t     inst_i;
    word_t     pc_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    reg_addr_t rs1_addr_o;
    reg_addr_t rs2_addr_o;
    logic      ack_o;
    logic      rd_we_o;
    reg_addr_t rd_addr_o;
    word_t     rd_data_o;
    word_t     pc_next_o;
    logic      inst_err_o;

    logic [15:0] lfsr_q;

    idex_unit dut (.*);

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    // 16-bit galois, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[XLEN-2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack_o !== level) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("timeout: ack_o never went to %0b", level));
            end
        end
    endtask

    // roughly one in eight is an illegal encoding
    task automatic gen_inst(output word_t inst);
        logic [2:0] kind;
        logic [2:0] f3;
        inst = rand_bits(32);
        f3   = inst[14:12];
        if (rand_bits(3) == 3'd0) begin
            kind = 3'(rand_bits(3));
            case (kind)
                3'd0, 3'd1: inst[6:0] = 7'b0000011; // load
                3'd2:       inst[6:0] = 7'b0100011; // store
                3'd3:       inst[6:0] = 7'b1110011; // system
                3'd4: begin
                    inst[6:0]   = OPC_OP;
                    inst[31:25] = 7'b0000001;       // m extension
                end
                3'd5: begin
                    inst[6:0]   = OPC_BRANCH;
                    inst[14:13] = 2'b01;            // funct3 010 or 011
                end
                3'd6: begin
                    inst[6:0] = OPC_JALR;
                    inst[12]  = 1'b1;
                end
                default: begin
                    inst[6:0] = OPC_OP;
                    inst[31]  = 1'b1;               // neither legal funct7
                end
            endcase
        end else begin
            kind = 3'(rand_bits(3));
            case (kind)
                3'd0: begin
                    inst[6:0] = OPC_OP_IMM;
                    if (f3 == F3_SLL || f3 == F3_SR) inst[31:25] = {1'b0, inst[30], 5'b0};
                end
                3'd1: begin
                    inst[6:0]   = OPC_OP;
                    inst[31:25] = {1'b0, inst[30], 5'b0};
                end
                3'd2: inst[6:0] = OPC_LUI;
                3'd3: inst[6:0] = OPC_AUIPC;
                3'd4: inst[6:0] = OPC_JAL;
                3'd5: begin
                    inst[6:0]   = OPC_JALR;
                    inst[14:12] = F3_JALR;
                end
                3'd6: begin
                    inst[6:0] = OPC_BRANCH;
                    if (f3[2:1] == 2'b01) inst[14] = 1'b1; // 010/011 -> bltu/bgeu
                end
                default: inst[6:0] = OPC_FENCE;
            endcase
        end
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input logic reg_form, input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000:  r = (alt && reg_form) ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else     r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // expected retire values from the rv32i rules
    task automatic model(input word_t inst, input word_t pc, input word_t a, input word_t b,
                         output logic we, output reg_addr_t rd, output word_t data,
                         output word_t nxt, output logic err);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       take;
        word_t      i_imm;
        word_t      b_imm;
        word_t      u_imm;
        word_t      j_imm;
        f3    = inst[14:12];
        f7    = inst[31:25];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        u_imm = {inst[31:12], 12'h000};
        j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        we    = 1'b0;
        data  = '0;
        nxt   = pc + 32'd4;
        err   = 1'b0;
        take  = 1'b0;
        case (inst[6:0])
            OPC_OP_IMM: begin
                we   = 1'b1;
                data = alu_ref(f3, inst[30], 1'b0, a, i_imm);
            end
            OPC_OP: begin
                err  = !(f7 == F7_BASE || f7 == F7_ALT);
                we   = 1'b1;
                data = alu_ref(f3, inst[30], 1'b1, a, b);
            end
            OPC_LUI: begin
                we   = 1'b1;
                data = u_imm;
            end
            OPC_AUIPC: begin
                we   = 1'b1;
                data = pc + u_imm;
            end
            OPC_JAL: begin
                we   = 1'b1;
                data = pc + 32'd4;
                nxt  = pc + j_imm;
            end
            OPC_JALR: begin
                err  = (f3 != F3_JALR);
                we   = 1'b1;
                data = pc + 32'd4;
                nxt  = a + i_imm;
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  take = (a == b);
                    F3_BNE:  take = (a != b);
                    F3_BLT:  take = ($signed(a) < $signed(b));
                    F3_BGE:  take = ($signed(a) >= $signed(b));
                    F3_BLTU: take = (a < b);
                    F3_BGEU: take = (a >= b);
                    default: err = 1'b1;
                endcase
                if (take) nxt = pc + b_imm;
            end
            OPC_FENCE: ;                            // only pc + 4
            default:   err = 1'b1;
        endcase
        if (err) begin
            we   = 1'b0;
            data = '0;
            nxt  = '0;
        end
        rd = we ? inst[11:7] : 5'd0;
    endtask

    initial begin
        word_t     inst;
        word_t     pc;
        word_t     rs1;
        word_t     rs2;
        logic      exp_we;
        reg_addr_t exp_rd;
        word_t     exp_data;
        word_t     exp_pc;
        logic      exp_err;
        lfsr_q     = 16'd36993;
        rst_n_i    = 1'b0;
        req_i      = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        for (int n = 0; n < N_TXN; n++) begin
            gen_inst(inst);
            pc  = rand_bits(30) << 2;
            rs1 = rand_bits(32);
            rs2 = (rand_bits(2) == 0) ? rs1 : rand_bits(32); // hit equal compares
            model(inst, pc, rs1, rs2, exp_we, exp_rd, exp_data, exp_pc, exp_err);
            inst_i     = inst;
            pc_i       = pc;
            rs1_data_i = rs1;
            rs2_data_i = rs2;
            req_i      = 1'b1;
            wait_ack(1'b1);
            check("rs1_addr_o", rs1_addr_o, inst[19:15]);
            check("rs2_addr_o", rs2_addr_o, inst[24:20]);
            check("rd_we_o", rd_we_o, exp_we);
            check("rd_addr_o", rd_addr_o, exp_rd);
            check("rd_data_o", rd_data_o, exp_data);
            check("pc_next_o", pc_next_o, exp_pc);
            check("inst_err_o", inst_err_o, exp_err);
            req_i = 1'b0;
            wait_ack(1'b0);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* idex_unit.f */
rtl/rv_isa_pkg.sv
rtl/idex_ctrl_pkg.sv
rtl/decode_if.sv
rtl/idex_decoder.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/retire_ctrl.sv
rtl/idex_unit.sv
dv/idex_unit_sva.sv
dv/idex_unit_tb.sv

/* rtl/branch_unit.sv */
module branch_unit import idex_ctrl_pkg::*; (
    decode_if.bru dec_i,
    output word_t pc_next_o,
    output word_t link_data_o
);

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  taken;
    word_t base;

    assign eq   = (dec_i.rs1_data == dec_i.rs2_data);
    assign lt_s = ($signed(dec_i.rs1_data) < $signed(dec_i.rs2_data));
    assign lt_u = (dec_i.rs1_data < dec_i.rs2_data);

    // pc + 4 doubles as the fall-through target
    assign link_data_o = dec_i.pc + PC_STEP;

    always_comb begin
        case (dec_i.pc_op)
            PC_BEQ:  taken = eq;
            PC_BNE:  taken = !eq;
            PC_BLT:  taken = lt_s;
            PC_BGE:  taken = !lt_s;
            PC_BLTU: taken = lt_u;
            PC_BGEU: taken = !lt_u;
            PC_JAL,
            PC_JALR: taken = 1'b1;   // unconditional
            default: taken = 1'b0;
        endcase
    end

    // jalr keeps bit 0 of the sum
    assign base = (dec_i.pc_op == PC_JALR) ? dec_i.rs1_data : dec_i.pc;

    assign pc_next_o = taken ? (base + dec_i.imm) : link_data_o;

endmodule

/* rtl/decode_if.sv */
interface decode_if import idex_ctrl_pkg::*; ();

    alu_op_e   alu_op;
    alu_src_e  alu_a_sel;
    alu_src_e  alu_b_sel;
    pc_op_e    pc_op;
    wb_src_e   wb_src;
    reg_addr_t rd;
    word_t     imm;       // already selected per format
    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      illegal;

    modport dec (
        output alu_op, alu_a_sel, alu_b_sel, pc_op, wb_src,
        output rd, imm, pc, rs1_data, rs2_data, illegal
    );

    modport alu (
        input alu_op, alu_a_sel, alu_b_sel, imm, pc, rs1_data, rs2_data
    );

    modport bru (
        input pc_op, imm, pc, rs1_data, rs2_data
    );

    modport ret (
        input wb_src, rd, illegal
    );

endinterface

/* rtl/idex_ctrl_pkg.sv */
package idex_ctrl_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t PC_STEP = 32'd4; // fall-through increment

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui
    } alu_op_e;

    // one field per operand: a is rs1/pc, b is rs2/imm
    typedef enum logic {
        SRC_REG = 1'b0,
        SRC_ALT = 1'b1
    } alu_src_e;

    typedef enum logic [3:0] {
        PC_SEQ, PC_BEQ, PC_BNE, PC_BLT, PC_BGE,
        PC_BLTU, PC_BGEU, PC_JAL, PC_JALR
    } pc_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LINK
    } wb_src_e;

endpackage

/* rtl/idex_decoder.sv */
module idex_decoder import idex_ctrl_pkg::*; import rv_isa_pkg::*; (
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    decode_if.dec     dec_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;      // inst bit 30
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign alt    = inst_i[30];

    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{(XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                    inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'h000};
    assign imm_j = {{(XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign dec_o.rd       = inst_i[11:7];
    assign dec_o.pc       = pc_i;
    assign dec_o.rs1_data = rs1_data_i;
    assign dec_o.rs2_data = rs2_data_i;

    // shared funct3 map of op and op-imm, sub only exists in register form
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sel_alt,
                                         input logic reg_form);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = (sel_alt && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = sel_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        dec_o.alu_op    = ALU_ADD;
        dec_o.alu_a_sel = SRC_REG;
        dec_o.alu_b_sel = SRC_ALT;
        dec_o.pc_op     = PC_SEQ;
        dec_o.wb_src    = WB_NONE;
        dec_o.imm       = imm_i;
        dec_o.illegal   = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                dec_o.alu_op = arith_op(funct3, alt, 1'b0);
                dec_o.wb_src = WB_ALU;
            end
            OPC_OP: begin
                if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    dec_o.alu_op    = arith_op(funct3, alt, 1'b1);
                    dec_o.alu_b_sel = SRC_REG;  // rs2
                    dec_o.wb_src    = WB_ALU;
                end else begin
                    dec_o.illegal = 1'b1;       // M ext lands here too
                end
            end
            OPC_LUI: begin
                dec_o.alu_op = ALU_PASS_B;
                dec_o.imm    = imm_u;
                dec_o.wb_src = WB_ALU;
            end
            OPC_AUIPC: begin
                dec_o.alu_a_sel = SRC_ALT;      // pc + imm
                dec_o.imm       = imm_u;
                dec_o.wb_src    = WB_ALU;
            end
            OPC_JAL: begin
                dec_o.imm    = imm_j;
                dec_o.pc_op  = PC_JAL;
                dec_o.wb_src = WB_LINK;
            end
            OPC_JALR: begin
                dec_o.pc_op   = PC_JALR;
                dec_o.wb_src  = WB_LINK;
                dec_o.illegal = (funct3 != F3_JALR);
            end
            OPC_BRANCH: begin
                dec_o.imm = imm_b;
                case (funct3)
                    F3_BEQ:  dec_o.pc_op = PC_BEQ;
                    F3_BNE:  dec_o.pc_op = PC_BNE;
                    F3_BLT:  dec_o.pc_op = PC_BLT;
                    F3_BGE:  dec_o.pc_op = PC_BGE;
                    F3_BLTU: dec_o.pc_op = PC_BLTU;
                    F3_BGEU: dec_o.pc_op = PC_BGEU;
                    default: dec_o.illegal = 1'b1;
                endcase
            end
            OPC_FENCE: begin
                dec_o.pc_op = PC_SEQ;           // just pc + 4
            end
            default: begin
                dec_o.illegal = 1'b1;           // load, store, system, unknown
            end
        endcase
        if (dec_o.illegal) begin
            dec_o.wb_src = WB_NONE;
            dec_o.pc_op  = PC_SEQ;
        end
    end

endmodule

/* rtl/idex_unit.sv */
module idex_unit import idex_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // requester side
    input  logic      req_i,
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    // registered results
    output logic      ack_o,
    output logic      rd_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o,
    output word_t     pc_next_o,
    output logic      inst_err_o
);

    word_t alu_result;
    word_t pc_next;
    word_t link_data;

    decode_if dec_if ();

    idex_decoder u_decoder (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .dec_o      (dec_if.dec)
    );

    int_alu u_alu (
        .dec_i        (dec_if.alu),
        .alu_result_o (alu_result)
    );

    branch_unit u_bru (
        .dec_i       (dec_if.bru),
        .pc_next_o   (pc_next),
        .link_data_o (link_data)
    );

    retire_ctrl u_retire (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .dec_i        (dec_if.ret),
        .alu_result_i (alu_result),
        .pc_next_i    (pc_next),
        .link_data_i  (link_data),
        .ack_o        (ack_o),
        .rd_we_o      (rd_we_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_o    (rd_data_o),
        .pc_next_o    (pc_next_o),
        .inst_err_o   (inst_err_o)
    );

endmodule

/* rtl/int_alu.sv */
module int_alu import idex_ctrl_pkg::*; (
    decode_if.alu dec_i,
    output word_t alu_result_o
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    assign op_a  = (dec_i.alu_a_sel == SRC_ALT) ? dec_i.pc  : dec_i.rs1_data;
    assign op_b  = (dec_i.alu_b_sel == SRC_ALT) ? dec_i.imm : dec_i.rs2_data;
    assign shamt = op_b[4:0]; // low five bits only

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_result_o = op_a + op_b;
            ALU_SUB:    alu_result_o = op_a - op_b;
            ALU_SLL:    alu_result_o = op_a << shamt;
            ALU_SLT: begin
                alu_result_o = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            ALU_SLTU: begin
                alu_result_o = {{(XLEN-1){1'b0}}, (op_a < op_b)};
            end
            ALU_XOR:    alu_result_o = op_a ^ op_b;
            ALU_SRL:    alu_result_o = op_a >> shamt;
            ALU_SRA:    alu_result_o = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_result_o = op_a | op_b;
            ALU_AND:    alu_result_o = op_a & op_b;
            ALU_PASS_B: alu_result_o = op_b;
            default:    alu_result_o = '0;
        endcase
    end

endmodule

/* rtl/retire_ctrl.sv */
module retire_ctrl import idex_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_i,
    decode_if.ret     dec_i,
    input  word_t     alu_result_i,
    input  word_t     pc_next_i,
    input  word_t     link_data_i,
    output logic      ack_o,
    output logic      rd_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o,
    output word_t     pc_next_o,
    output logic      inst_err_o
);

    typedef enum logic {
        ST_IDLE,
        ST_DONE
    } state_e;

    state_e state_q;
    logic   wr_en;
    word_t  wr_data;

    assign wr_en = (dec_i.wb_src != WB_NONE);

    always_comb begin
        case (dec_i.wb_src)
            WB_ALU:  wr_data = alu_result_i;
            WB_LINK: wr_data = link_data_i;
            default: wr_data = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            rd_we_o    <= 1'b0;
            rd_addr_o  <= '0;
            rd_data_o  <= '0;
            pc_next_o  <= '0;
            inst_err_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q    <= ST_DONE;
                        rd_we_o    <= wr_en;
                        rd_addr_o  <= wr_en ? dec_i.rd : '0; // zero when not writing
                        rd_data_o  <= wr_data;
                        pc_next_o  <= dec_i.illegal ? '0 : pc_next_i;
                        inst_err_o <= dec_i.illegal;
                    end
                end
                default: begin
                    if (!req_i) begin
                        state_q <= ST_IDLE;  // results stay until next capture
                    end
                end
            endcase
        end
    end

    assign ack_o = (state_q == ST_DONE);

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes of the kept instruction classes
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_FENCE  = 7'b0001111
    } opcode_e;

    // arithmetic and shift variants, op and op-imm
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl/sra by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // jalr has a single legal encoding
    localparam logic [2:0] F3_JALR    = 3'b000;

    // conditional branches
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // sub, sra

endpackage
